// File: tb.f
+incdir+.
bus_pkg.sv
disp_pkg.sv
i2c_adc_reader.sv
spi_slave.sv
seg_display.sv
adc_panel_top.sv
tb_i2c_adc_model.sv
tb_adc_panel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the panel testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_adc_panel -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_adc_panel.sv
// directed testbench for the sensor front panel
// drives the SPI lines, models the ADC on a wired SDA and checks the scanned display
`timescale 1ns/1ps
`include "panel_cfg.svh"

module tb_adc_panel;

	localparam int TXN_CYCLES  = 39 * 4 * `PANEL_SCL_DIV;   // worst full I2C poll
	localparam int NUM_TESTS   = 5;
	localparam int SCAN_LIMIT  = 2 * `PANEL_DIGITS * `PANEL_SCAN_CYCLES;
	localparam int SPI_HALF    = 6;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       scl;
	logic       sda_oe;
	logic       sda_line;
	logic       model_pull;
	logic       cs_n;
	logic       sclk;
	logic       mosi;
	logic       miso;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;
	logic       adc_err;
	logic [7:0] adc_value;
	logic       nack_req;
	logic [31:0] lfsr_state;

	// expected display contents
	logic       have_adc;
	logic [7:0] adc_val;
	logic       have_spi;
	logic [7:0] spi_val;
	logic [7:0] spi_prev;

	logic [15:0][7:0] font = {
		8'h8e, 8'h86, 8'ha1, 8'hc6, 8'h83, 8'h88, 8'h90, 8'h80,
		8'hf8, 8'h82, 8'h92, 8'h99, 8'hb0, 8'ha4, 8'hf9, 8'hc0
	};

	assign sda_line = !(sda_oe || model_pull);   // pull-up with two open drains

	adc_panel_top adc_panel_top_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda_oe     (sda_oe),
		.sda_in     (sda_line),
		.cs_n       (cs_n),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.adc_err    (adc_err)
	);

	tb_i2c_adc_model adc_model (
		.scl      (scl),
		.sda      (sda_line),
		.value    (adc_value),
		.nack_req (nack_req),
		.sda_pull (model_pull)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	initial begin
		#(64'(NUM_TESTS) * TXN_CYCLES * 4 * 100);
		fail_now("watchdog expired before the tests finished");
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] val;
		logic       fb;
		val = '0;
		for (int i = 0; i < 8; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val        = {val[6:0], fb};
		end
		return val;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
	endtask

	// waits for the digit to come up in the scan, then checks its segments
	task automatic compare_seg(input disp_pkg::seg_out_t exp);
		int waited;
		waited = 0;
		while (seg_choice !== exp.sel) begin
			@(negedge sys_clk);
			waited++;
			if (waited > SCAN_LIMIT)
				fail_now($sformatf("display never selected digit pattern %h", exp.sel));
		end
		if (seg_number !== exp.seg)
			fail_now($sformatf("[ERROR] seg_number (sel %h): got %h expected %h",
				exp.sel, seg_number, exp.seg));
	endtask

	task automatic compare_byte(input bus_pkg::spi_byte_t got, input bus_pkg::spi_byte_t exp);
		if (got.data !== exp.data)
			fail_now($sformatf("[ERROR] miso byte: got %h expected %h", got.data, exp.data));
	endtask

	function automatic logic [7:0] expected_pattern(input int d);
		logic [7:0] pat;
		pat = 8'hff;
		case (d)
		0: if (have_adc) pat = font[adc_val % 10];
		1: if (have_adc && adc_val >= 10) pat = font[(adc_val / 10) % 10];
		2: if (have_adc && adc_val >= 100) pat = font[adc_val / 100];
		5: if (have_adc) pat = 8'hbf;   // separator
		6: if (have_spi) pat = font[spi_val[3:0]];
		7: if (have_spi) pat = font[spi_val[7:4]];
		default: pat = 8'hff;
		endcase
		return pat;
	endfunction

	task automatic check_display();
		disp_pkg::seg_out_t exp;
		repeat (2) @(negedge sys_clk);   // frame, then segment register
		for (int d = 0; d < `PANEL_DIGITS; d++) begin
			exp.sel = ~(8'(1) << d);
			exp.seg = expected_pattern(d);
			compare_seg(exp);
		end
	endtask

	task automatic wait_sample();
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (adc_panel_top_inst.sample.vld !== 1'b1) begin
			@(negedge sys_clk);
			waited++;
			if (waited > 2 * TXN_CYCLES)
				fail_now("no ADC sample arrived in time");
		end
	endtask

	// one mode-3 frame, miso read on each rising sclk
	task automatic spi_frame(input logic [7:0] tx, output logic [7:0] rx_bits);
		wait_cycles(1);
		cs_n = 1'b0;
		wait_cycles(SPI_HALF);
		for (int i = 7; i >= 0; i--) begin
			sclk = 1'b0;
			mosi = tx[i];
			wait_cycles(SPI_HALF);
			sclk       = 1'b1;
			rx_bits[i] = miso;
			wait_cycles(SPI_HALF);
		end
		cs_n = 1'b1;
		wait_cycles(SPI_HALF);
	endtask

	task automatic spi_send_checked(input logic [7:0] tx);
		bus_pkg::spi_byte_t got;
		bus_pkg::spi_byte_t exp;
		got.vld  = 1'b1;
		exp.vld  = 1'b1;
		exp.data = spi_prev + 8'd2;
		spi_frame(tx, got.data);
		compare_byte(got, exp);
		spi_prev = tx;
		spi_val  = tx;
		have_spi = 1'b1;
	endtask

	task automatic test_reset();
		disp_pkg::seg_out_t idle;
		idle.seg = 8'hff;
		idle.sel = 8'hff;
		repeat (2) @(negedge sys_clk);
		compare_seg(idle);
		compare_bit("miso", miso, 1'b1);
		compare_bit("scl", scl, 1'b1);
		wait_cycles(3);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		compare_seg(idle);
		compare_bit("miso", miso, 1'b1);
		compare_bit("scl", scl, 1'b1);
		compare_bit("sda_oe", sda_oe, 1'b0);
	endtask

	task automatic test_adc_decimal();
		logic [7:0] vals [3];
		vals = '{8'd7, 8'd42, 8'd213};
		foreach (vals[i]) begin
			adc_value = vals[i];
			wait_sample();
			wait_sample();   // second poll surely carries the new value
			adc_val  = vals[i];
			have_adc = 1'b1;
			check_display();
		end
	endtask

	task automatic test_spi_hex();
		repeat (3) begin
			spi_send_checked(rand_byte());
			check_display();
		end
	endtask

	task automatic test_spi_echo();
		repeat (4)
			spi_send_checked(rand_byte());
	endtask

	task automatic test_adc_nack();
		logic [7:0] fresh;
		int         waited;
		fresh     = rand_byte();
		waited    = 0;
		adc_value = fresh;
		nack_req  = 1'b1;
		@(negedge sys_clk);
		while (adc_err !== 1'b1) begin
			@(negedge sys_clk);
			waited++;
			if (waited > 2 * TXN_CYCLES)
				fail_now("adc_err never pulsed on a refused address");
		end
		nack_req = 1'b0;
		check_display();   // still the old sample
		wait_sample();
		adc_val = fresh;
		check_display();
	endtask

	initial begin
		sys_rst_n  = 1'b0;
		cs_n       = 1'b1;
		sclk       = 1'b1;
		mosi       = 1'b0;
		adc_value  = 8'h00;
		nack_req   = 1'b0;
		lfsr_state = 32'h7282_cf08;
		have_adc   = 1'b0;
		adc_val    = '0;
		have_spi   = 1'b0;
		spi_val    = '0;
		spi_prev   = '0;
		test_reset();
		test_adc_decimal();
		test_spi_hex();
		test_spi_echo();
		test_adc_nack();
		$display("Test passed");
		$finish;
	end

endmodule

// File: tb_i2c_adc_model.sv
// behavioral I2C ADC slave for the panel testbench
// acks its own address and the expected register byte, then returns value on a read
// nack_req makes it refuse every address byte while it is high
`timescale 1ns/1ps
`include "panel_cfg.svh"

module tb_i2c_adc_model (
	input  logic       scl,
	input  logic       sda,        // resolved wired line
	input  logic [7:0] value,
	input  logic       nack_req,
	output logic       sda_pull    // high pulls sda low
);

	logic       active;
	logic       is_addr;
	logic       reading;
	logic [3:0] cnt;       // scl rises seen in this byte, 9 after the ack slot
	logic [7:0] shreg;
	logic [7:0] rd_byte;

	initial begin
		active   = 1'b0;
		is_addr  = 1'b0;
		reading  = 1'b0;
		cnt      = '0;
		shreg    = '0;
		rd_byte  = '0;
		sda_pull = 1'b0;
	end

	// start and repeated start
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active  = 1'b1;
			is_addr = 1'b1;
			reading = 1'b0;
			cnt     = '0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin   // stop
			active  = 1'b0;
			reading = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			if (!reading && cnt < 4'd8)
				shreg = {shreg[6:0], sda};
			cnt = cnt + 1'b1;
		end
	end

	always @(negedge scl) begin
		if (active) begin
			if (cnt == 4'd8) begin
				if (reading) begin
					sda_pull = 1'b0;   // master sends NACK here
				end else if (is_addr && (shreg[7:1] != `PANEL_ADC_DEV_ID || nack_req)) begin
					sda_pull = 1'b0;
					active   = 1'b0;
				end else if (!is_addr && shreg != `PANEL_ADC_REG) begin
					sda_pull = 1'b0;   // wrong register pointer
					active   = 1'b0;
				end else begin
					sda_pull = 1'b1;
					if (is_addr && shreg[0])
						rd_byte = value;   // latched at the read address ack
				end
			end else if (cnt == 4'd9) begin
				cnt      = '0;
				sda_pull = 1'b0;
				if (is_addr && shreg[0]) begin
					reading  = 1'b1;
					sda_pull = !rd_byte[7];
				end
				is_addr = 1'b0;
			end else if (reading && cnt > 4'd0) begin
				sda_pull = !rd_byte[7 - cnt];
			end
		end
	end

endmodule

// File: adc_panel_top.sv
// sensor front panel with an I2C ADC poller, a mode-3 SPI slave and the display
// sda comes as sda_in plus sda_oe for an open-drain pad outside this block
`timescale 1ns/1ps

module adc_panel_top (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	output logic       scl,
	output logic       sda_oe,
	input  logic       sda_in,
	input  logic       cs_n,
	input  logic       sclk,
	input  logic       mosi,
	output logic       miso,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice,
	output logic       adc_err
);

	bus_pkg::adc_sample_t sample;
	bus_pkg::spi_byte_t   spi_rx;
	disp_pkg::seg_out_t   seg_out;

	i2c_adc_reader i2c_adc_reader_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scl       (scl),
		.sda_oe    (sda_oe),
		.sda_in    (sda_in),
		.sample    (sample),
		.ack_err   (adc_err)
	);

	spi_slave spi_slave_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs_n      (cs_n),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.rx        (spi_rx)
	);

	seg_display seg_display_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.sample    (sample),
		.rx        (spi_rx),
		.seg_out   (seg_out)
	);

	assign seg_number = seg_out.seg;
	assign seg_choice = seg_out.sel;

endmodule

// File: seg_display.sv
// eight-digit multiplexed display for the panel
// digits 0..2 show the ADC sample in decimal, 6..7 the SPI byte in hex, 5 a dash
`timescale 1ns/1ps
`include "panel_cfg.svh"

module seg_display (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  bus_pkg::adc_sample_t sample,
	input  bus_pkg::spi_byte_t   rx,
	output disp_pkg::seg_out_t   seg_out
);

	localparam int SCAN_W = $clog2(`PANEL_SCAN_CYCLES + 1);
	localparam int IDX_W  = $clog2(`PANEL_DIGITS);

	disp_pkg::disp_frame_t frame;
	disp_pkg::digit_t      dec_hund;
	disp_pkg::digit_t      dec_tens;
	disp_pkg::digit_t      dec_ones;
	logic [SCAN_W-1:0]     scan_cnt;
	logic                  scan_wrap;
	logic                  scan_on;
	logic [IDX_W-1:0]      digit_idx;
	logic [7:0]            cur_seg;

	assign dec_hund = disp_pkg::digit_t'(sample.value / 8'd100);
	assign dec_tens = disp_pkg::digit_t'((sample.value / 8'd10) % 8'd10);
	assign dec_ones = disp_pkg::digit_t'(sample.value % 8'd10);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame.codes <= '0;
			frame.blank <= '1;
			frame.dash  <= '0;
		end else begin
			if (sample.vld) begin
				frame.codes[0] <= dec_ones;
				frame.codes[1] <= dec_tens;
				frame.codes[2] <= dec_hund;
				frame.blank[0] <= 1'b0;
				frame.blank[1] <= (sample.value < 8'd10);   // leading zeros off
				frame.blank[2] <= (sample.value < 8'd100);
				frame.dash[5]  <= 1'b1;   // separator comes up with the first sample
			end
			if (rx.vld) begin
				frame.codes[6]   <= rx.data[3:0];
				frame.codes[7]   <= rx.data[7:4];
				frame.blank[7:6] <= 2'b00;
			end
		end
	end

	// digit scan, starts after one full period
	assign scan_wrap = (scan_cnt == SCAN_W'(`PANEL_SCAN_CYCLES - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt  <= '0;
			scan_on   <= 1'b0;
			digit_idx <= '0;
		end else begin
			scan_cnt <= scan_wrap ? '0 : scan_cnt + 1'b1;
			if (scan_wrap) begin
				scan_on <= 1'b1;
				if (scan_on)
					digit_idx <= digit_idx + 1'b1;
			end
		end
	end

	always_comb begin
		if (frame.dash[digit_idx])
			cur_seg = disp_pkg::SEG_DASH;
		else if (frame.blank[digit_idx])
			cur_seg = disp_pkg::SEG_BLANK;
		else
			cur_seg = disp_pkg::seg_font(frame.codes[digit_idx]);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_out.seg <= '1;
			seg_out.sel <= '1;
		end else if (scan_on) begin
			seg_out.seg <= cur_seg;
			seg_out.sel <= ~(`PANEL_DIGITS'(1) << digit_idx);
		end
	end

	a_one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$past(scan_on) |-> $onehot(~seg_out.sel));

endmodule

// File: spi_slave.sv
// mode-3 SPI slave, one byte per frame, MSB first
// each frame answers with the byte of the previous frame plus two
`timescale 1ns/1ps

module spi_slave (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               cs_n,
	input  logic               sclk,
	input  logic               mosi,
	output logic               miso,
	output bus_pkg::spi_byte_t rx
);

	logic [2:0] sclk_sr;   // two sync stages plus edge history
	logic [2:0] cs_sr;
	logic [1:0] mosi_sr;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       cs_fall;
	logic       cs_high;
	logic [2:0] bit_cnt;
	logic [7:0] rx_shift;
	logic [7:0] rx_data;
	logic       rx_vld;
	logic [7:0] tx_shift;
	logic [7:0] tx_src;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sclk_sr <= '1;   // idle high in mode 3
			cs_sr   <= '1;
			mosi_sr <= '0;
		end else begin
			sclk_sr <= {sclk_sr[1:0], sclk};
			cs_sr   <= {cs_sr[1:0], cs_n};
			mosi_sr <= {mosi_sr[0], mosi};
		end
	end

	assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
	assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
	assign cs_fall   = ~cs_sr[1] & cs_sr[2];
	assign cs_high   = cs_sr[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
			rx_data <= '0;   // first reply is 8'h02
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (cs_high) begin
				bit_cnt <= '0;   // partial frame dropped
			end else if (sclk_rise) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7) begin
					rx_data <= {rx_shift[6:0], mosi_sr[1]};
					rx_vld  <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!cs_high && sclk_rise)
			rx_shift <= {rx_shift[6:0], mosi_sr[1]};
	end

	// reply loaded at frame start, first bit goes out on the first falling edge
	assign tx_src = cs_fall ? rx_data + 8'd2 : tx_shift;

	always_ff @(posedge sys_clk) begin
		if (sclk_fall)
			tx_shift <= {tx_src[6:0], 1'b0};
		else if (cs_fall)
			tx_shift <= tx_src;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			miso <= 1'b1;
		else if (cs_high)
			miso <= 1'b1;
		else if (sclk_fall)
			miso <= tx_src[7];
	end

	assign rx.vld  = rx_vld;
	assign rx.data = rx_data;

	a_vld_in_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx.vld |-> !cs_n);

endmodule

// File: i2c_adc_reader.sv
// I2C master that keeps polling the ADC, one sample byte per transaction
// sequence is start, addr+W, register, repeated start, addr+R, byte with NACK, stop
// a missing ACK sends a stop, pulses ack_err and starts over
`timescale 1ns/1ps
`include "panel_cfg.svh"

module i2c_adc_reader (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	output logic                 scl,
	output logic                 sda_oe,    // high pulls sda low
	input  logic                 sda_in,
	output bus_pkg::adc_sample_t sample,
	output logic                 ack_err
);

	localparam int DIV_W = $clog2(`PANEL_SCL_DIV + 1);

	typedef enum logic [2:0] {
		ST_WAIT,
		ST_START,
		ST_WBIT,
		ST_RBIT,
		ST_STOP
	} state_t;

	state_t           state;
	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [1:0]       qtr;        // quarter inside the current bit
	logic [3:0]       bit_cnt;    // 8 is the ack slot
	logic [1:0]       byte_idx;   // 0 addr write, 1 register, 2 addr read
	logic [2:0]       wait_cnt;
	logic [7:0]       tx_byte;
	logic [7:0]       rx_byte;
	logic             sample_vld;

	assign tick = (div_cnt == DIV_W'(`PANEL_SCL_DIV - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			div_cnt <= '0;
		else
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
	end

	// scl moves on quarters 0 and 2, sda on 1 and 3
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= ST_WAIT;
			qtr        <= '0;
			bit_cnt    <= '0;
			byte_idx   <= '0;
			wait_cnt   <= '0;
			scl        <= 1'b1;
			sda_oe     <= 1'b0;
			sample_vld <= 1'b0;
			ack_err    <= 1'b0;
		end else begin
			sample_vld <= 1'b0;
			ack_err    <= 1'b0;
			if (state == ST_WAIT) begin
				wait_cnt <= wait_cnt + 1'b1;
				if (wait_cnt == 3'd7)
					state <= ST_START;
			end else if (tick) begin
				qtr <= qtr + 1'b1;
				case (qtr)
				2'd0: scl <= 1'b0;
				2'd1: sda_oe <= (state == ST_STOP) ||
						(state == ST_WBIT && bit_cnt != 4'd8 && !tx_byte[7]);
				2'd2: scl <= 1'b1;
				default: begin
					bit_cnt <= bit_cnt + 1'b1;
					case (state)
					ST_START: begin
						sda_oe  <= 1'b1;   // sda falls while scl high
						bit_cnt <= '0;
						state   <= ST_WBIT;
					end
					ST_WBIT: if (bit_cnt == 4'd8) begin
						bit_cnt <= '0;
						if (sda_in) begin   // no ACK from the ADC
							ack_err <= 1'b1;
							state   <= ST_STOP;
						end else if (byte_idx == 2'd0) begin
							byte_idx <= 2'd1;
						end else if (byte_idx == 2'd1) begin
							byte_idx <= 2'd2;
							state    <= ST_START;   // repeated start
						end else begin
							state <= ST_RBIT;
						end
					end
					ST_RBIT: if (bit_cnt == 4'd8) begin
						sample_vld <= 1'b1;   // NACK slot done
						state      <= ST_STOP;
					end
					default: begin
						sda_oe   <= 1'b0;   // stop condition
						byte_idx <= '0;
						state    <= ST_START;
					end
					endcase
				end
				endcase
			end
		end
	end

	// shift registers, advanced at the end of each bit
	always_ff @(posedge sys_clk) begin
		if (tick && qtr == 2'd3) begin
			case (state)
			ST_START: tx_byte <= {`PANEL_ADC_DEV_ID, byte_idx[1]};
			ST_WBIT:  tx_byte <= (bit_cnt == 4'd8) ? `PANEL_ADC_REG : {tx_byte[6:0], 1'b0};
			ST_RBIT:  if (bit_cnt != 4'd8) rx_byte <= {rx_byte[6:0], sda_in};
			default:  ;
			endcase
		end
	end

	assign sample.vld   = sample_vld;
	assign sample.value = rx_byte;

	a_lines_apart: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!($changed(scl) && $changed(sda_oe)));
	a_vld_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample.vld |=> !sample.vld);

endmodule

// File: disp_pkg.sv
// display types for the segment driver and the testbench
// a frame holds one hex code per digit plus blank and dash masks
`include "panel_cfg.svh"

package disp_pkg;

	typedef logic [3:0] digit_t;   // hex value 0..f

	typedef struct packed {
		digit_t [`PANEL_DIGITS-1:0] codes;
		logic   [`PANEL_DIGITS-1:0] blank;
		logic   [`PANEL_DIGITS-1:0] dash;    // overrides blank and code
	} disp_frame_t;

	typedef struct packed {
		logic [7:0]               seg;   // {dp, g..a}, active low
		logic [`PANEL_DIGITS-1:0] sel;   // active low, bit 0 is digit 0
	} seg_out_t;

	localparam logic [7:0] SEG_BLANK = 8'hff;
	localparam logic [7:0] SEG_DASH  = 8'hbf;   // segment g only

	// entry 15 first
	localparam logic [15:0][7:0] SEG_FONT = {
		8'h8e, 8'h86, 8'ha1, 8'hc6, 8'h83, 8'h88, 8'h90, 8'h80,
		8'hf8, 8'h82, 8'h92, 8'h99, 8'hb0, 8'ha4, 8'hf9, 8'hc0
	};

	function automatic logic [7:0] seg_font(input digit_t code);
		return SEG_FONT[code];   // dp stays off
	endfunction

endpackage

// File: bus_pkg.sv
// result types handed from the I2C and SPI front ends to the display
// every vld is a single-cycle strobe, the receiver just latches the payload
package bus_pkg;

	typedef struct packed {
		logic       vld;
		logic [7:0] value;   // raw ADC code
	} adc_sample_t;

	typedef struct packed {
		logic       vld;     // pulses when a full frame is in
		logic [7:0] data;
	} spi_byte_t;

endpackage

// File: panel_cfg.svh
// build settings for the sensor front panel
// values suit simulation; raise the divider and scan period for the board clock
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

`define PANEL_ADC_DEV_ID   7'h54   // 7-bit ADC address
`define PANEL_ADC_REG      8'h00   // register pointer written before each read
`define PANEL_SCL_DIV      4       // sys_clk cycles per scl quarter period
`define PANEL_SCAN_CYCLES  8       // sys_clk cycles per displayed digit

// digits on the multiplexed display
`define PANEL_DIGITS       8

`endif
